//--- Makefile
SIM := obj_dir/Vaes_decrypter_tb

.PHONY: all run clean

all: $(SIM)

$(SIM): build.f $(wildcard rtl/*.sv sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module aes_decrypter_tb -f build.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

//--- build.f
rtl/aes_pkg.sv
rtl/aes_sbox.sv
rtl/aes_inv_mix_columns.sv
rtl/aes_inv_round.sv
rtl/aes_key_schedule.sv
rtl/aes_decrypter.sv
sim/tb_clock_gen.sv
sim/aes_decrypter_tb.sv

//--- rtl/aes_decrypter.sv
`timescale 1ns/10ps
`default_nettype none

module aes_decrypter (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            start,
    input  wire aes_pkg::block_t cipher_text,
    input  wire aes_pkg::block_t key,
    output logic                 busy,
    output logic                 done,
    output aes_pkg::block_t      plain_text
);

    localparam aes_pkg::round_idx_t LAST_ROUND = aes_pkg::round_idx_t'(aes_pkg::NUM_ROUNDS);

    aes_pkg::dec_state_e fsm;
    aes_pkg::round_idx_t cnt;        // cycle within expand or decrypt
    aes_pkg::round_idx_t rd_idx;
    aes_pkg::block_t     state_q;    // working block
    aes_pkg::block_t     round_key;
    aes_pkg::block_t     next_state;
    logic                load;
    logic                step;
    logic                mix_en;

    assign load = (fsm == aes_pkg::ST_IDLE) && start;
    assign step = (fsm == aes_pkg::ST_EXPAND);

    // keys are read back from 10 down to 0
    assign rd_idx = (fsm == aes_pkg::ST_DECRYPT) ? aes_pkg::round_idx_t'(LAST_ROUND - cnt) : '0;
    assign mix_en = (cnt != '0);

    aes_key_schedule u_key_schedule (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .step      (step),
        .key       (key),
        .rd_idx    (rd_idx),
        .round_key (round_key)
    );

    aes_inv_round u_inv_round (
        .state      (state_q),
        .round_key  (round_key),
        .mix_en     (mix_en),
        .next_state (next_state)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fsm        <= aes_pkg::ST_IDLE;
            cnt        <= '0;
            busy       <= 1'b0;
            done       <= 1'b0;
            plain_text <= '0;
        end
        else
        begin
            done <= 1'b0;
            case (fsm)
                aes_pkg::ST_IDLE:
                    if (start)
                    begin
                        fsm  <= aes_pkg::ST_EXPAND;
                        cnt  <= '0;
                        busy <= 1'b1;
                    end
                aes_pkg::ST_EXPAND:
                    if (cnt == LAST_ROUND - 4'd1)  // key 10 lands on this edge
                    begin
                        fsm <= aes_pkg::ST_DECRYPT;
                        cnt <= '0;
                    end
                    else
                        cnt <= cnt + 4'd1;
                aes_pkg::ST_DECRYPT:
                    if (cnt == LAST_ROUND)
                    begin
                        // final add with the cipher key
                        plain_text <= state_q ^ round_key;
                        fsm        <= aes_pkg::ST_IDLE;
                        busy       <= 1'b0;
                        done       <= 1'b1;
                    end
                    else
                        cnt <= cnt + 4'd1;
                default:
                    fsm <= aes_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
            state_q <= cipher_text;
        else if (fsm == aes_pkg::ST_DECRYPT && cnt != LAST_ROUND)
            state_q <= next_state;
    end

    a_done_single: assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    );

    // busy drops on the same edge that raises done
    a_done_not_busy: assert property (
        @(posedge clk) disable iff (rst)
        done |-> !busy && $fell(busy)
    );

endmodule

`default_nettype wire

//--- rtl/aes_inv_mix_columns.sv
`timescale 1ns/10ps
`default_nettype none

module aes_inv_mix_columns (
    input  wire aes_pkg::block_t in_block,
    output aes_pkg::block_t      out_block
);

    // one column through the 14/11/13/9 circulant
    function automatic aes_pkg::word_t inv_mix_col(input aes_pkg::word_t c);
        aes_pkg::word_t r;
        r.b0 = aes_pkg::gf_mul(c.b0, 8'h0e) ^ aes_pkg::gf_mul(c.b1, 8'h0b)
             ^ aes_pkg::gf_mul(c.b2, 8'h0d) ^ aes_pkg::gf_mul(c.b3, 8'h09);
        r.b1 = aes_pkg::gf_mul(c.b0, 8'h09) ^ aes_pkg::gf_mul(c.b1, 8'h0e)
             ^ aes_pkg::gf_mul(c.b2, 8'h0b) ^ aes_pkg::gf_mul(c.b3, 8'h0d);
        r.b2 = aes_pkg::gf_mul(c.b0, 8'h0d) ^ aes_pkg::gf_mul(c.b1, 8'h09)
             ^ aes_pkg::gf_mul(c.b2, 8'h0e) ^ aes_pkg::gf_mul(c.b3, 8'h0b);
        r.b3 = aes_pkg::gf_mul(c.b0, 8'h0b) ^ aes_pkg::gf_mul(c.b1, 8'h0d)
             ^ aes_pkg::gf_mul(c.b2, 8'h09) ^ aes_pkg::gf_mul(c.b3, 8'h0e);
        return r;
    endfunction

    // columns are independent
    assign out_block.c0 = inv_mix_col(in_block.c0);
    assign out_block.c1 = inv_mix_col(in_block.c1);
    assign out_block.c2 = inv_mix_col(in_block.c2);
    assign out_block.c3 = inv_mix_col(in_block.c3);

endmodule

`default_nettype wire

//--- rtl/aes_inv_round.sv
`timescale 1ns/10ps
`default_nettype none

module aes_inv_round (
    input  wire aes_pkg::block_t state,
    input  wire aes_pkg::block_t round_key,
    input  wire logic            mix_en,
    output aes_pkg::block_t      next_state
);

    logic [aes_pkg::BLOCK_W-1:0] key_added;
    aes_pkg::block_t             mixed;
    aes_pkg::block_t             mix_sel;
    aes_pkg::block_t             shifted;

    assign key_added = state ^ round_key;

    aes_inv_mix_columns u_inv_mix (
        .in_block  (aes_pkg::block_t'(key_added)),
        .out_block (mixed)
    );

    // first decrypt round has no mix
    assign mix_sel = mix_en ? mixed : aes_pkg::block_t'(key_added);

    // row r moves right by r columns
    assign shifted.c0 = {mix_sel.c0.b0, mix_sel.c3.b1, mix_sel.c2.b2, mix_sel.c1.b3};
    assign shifted.c1 = {mix_sel.c1.b0, mix_sel.c0.b1, mix_sel.c3.b2, mix_sel.c2.b3};
    assign shifted.c2 = {mix_sel.c2.b0, mix_sel.c1.b1, mix_sel.c0.b2, mix_sel.c3.b3};
    assign shifted.c3 = {mix_sel.c3.b0, mix_sel.c2.b1, mix_sel.c1.b2, mix_sel.c0.b3};

    genvar i;
    generate
        for (i = 0; i < 16; i++)
        begin : g_sub
            aes_sbox #(
                .INVERSE (1'b1)
            ) u_sbox (
                .in_byte  (shifted[i*8 +: 8]),
                .out_byte (next_state[i*8 +: 8])
            );
        end
    endgenerate

endmodule

`default_nettype wire

//--- rtl/aes_key_schedule.sv
`timescale 1ns/10ps
`default_nettype none

module aes_key_schedule (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                load,
    input  wire logic                step,
    input  wire aes_pkg::block_t     key,
    input  wire aes_pkg::round_idx_t rd_idx,
    output aes_pkg::block_t          round_key
);

    aes_pkg::block_t     keys [0:aes_pkg::NUM_ROUNDS];  // round keys 0..10
    aes_pkg::round_idx_t wr_idx;                         // last key written
    aes_pkg::round_idx_t nxt_idx;
    aes_pkg::block_t     last_key;
    aes_pkg::block_t     next_key;
    aes_pkg::word_t      rot_word;
    aes_pkg::word_t      sub_word;
    aes_pkg::word_t      rcon_word;

    assign nxt_idx  = aes_pkg::round_idx_t'(wr_idx + 4'd1);
    assign last_key = keys[wr_idx];

    assign rot_word = {last_key.c3.b1, last_key.c3.b2, last_key.c3.b3, last_key.c3.b0};

    genvar i;
    generate
        for (i = 0; i < 4; i++)
        begin : g_subword
            aes_sbox #(
                .INVERSE (1'b0)
            ) u_sbox (
                .in_byte  (rot_word[i*8 +: 8]),
                .out_byte (sub_word[i*8 +: 8])
            );
        end
    endgenerate

    assign rcon_word = {aes_pkg::rcon(nxt_idx), 24'h000000};

    // xor chain across the columns
    assign next_key.c0 = last_key.c0 ^ sub_word ^ rcon_word;
    assign next_key.c1 = last_key.c1 ^ next_key.c0;
    assign next_key.c2 = last_key.c2 ^ next_key.c1;
    assign next_key.c3 = last_key.c3 ^ next_key.c2;

    always_ff @(posedge clk)
    begin
        if (load)
            keys[0] <= key;
        else if (step)
            keys[nxt_idx] <= next_key;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            wr_idx <= '0;
        else if (load)
            wr_idx <= '0;
        else if (step)
            wr_idx <= nxt_idx;
    end

    assign round_key = keys[rd_idx];

    // the controller must stop stepping once key 10 exists
    a_no_step_past_last: assert property (
        @(posedge clk) disable iff (rst)
        step |-> (wr_idx < aes_pkg::round_idx_t'(aes_pkg::NUM_ROUNDS))
    );

endmodule

`default_nettype wire

//--- rtl/aes_pkg.sv
`default_nettype none

package aes_pkg;

    localparam int BLOCK_W    = 128;  // block and key width
    localparam int NUM_ROUNDS = 10;

    typedef logic [7:0] byte_t;

    // b0 is the top byte of a column
    typedef struct packed {
        byte_t b0;
        byte_t b1;
        byte_t b2;
        byte_t b3;
    } word_t;

    typedef struct packed {
        word_t c0;
        word_t c1;
        word_t c2;
        word_t c3;
    } block_t;

    typedef logic [3:0] round_idx_t;  // 0 to 10

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXPAND,
        ST_DECRYPT
    } dec_state_e;

    // multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic byte_t xtime(input byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic byte_t gf_mul(input byte_t a, input byte_t b);
        byte_t acc;
        byte_t p;
        acc = '0;
        p   = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ p;
            p = xtime(p);
        end
        return acc;
    endfunction

    // a^254 by square and multiply; zero stays zero
    function automatic byte_t gf_inv(input byte_t a);
        byte_t sq;
        byte_t acc;
        sq  = a;
        acc = 8'h01;
        for (int i = 1; i < 8; i++)
        begin
            sq  = gf_mul(sq, sq);   // a^(2^i)
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    function automatic byte_t rcon(input round_idx_t idx);
        byte_t r;
        r = 8'h01;
        for (int i = 1; i < NUM_ROUNDS; i++)
        begin
            if (i < idx)
                r = xtime(r);
        end
        return (idx == 4'd0) ? 8'h00 : r;
    endfunction

endpackage

`default_nettype wire

//--- rtl/aes_sbox.sv
`timescale 1ns/10ps
`default_nettype none

module aes_sbox #(
    parameter bit INVERSE = 1'b0  // 0 forward, 1 inverse
) (
    input  wire aes_pkg::byte_t in_byte,
    output aes_pkg::byte_t      out_byte
);

    function automatic aes_pkg::byte_t rotl(input aes_pkg::byte_t v, input int unsigned n);
        return aes_pkg::byte_t'((v << n) | (v >> (8 - n)));
    endfunction

    generate
        if (INVERSE)
        begin : g_inv
            aes_pkg::byte_t pre;

            // undo the affine map first, then invert
            assign pre      = rotl(in_byte, 1) ^ rotl(in_byte, 3) ^ rotl(in_byte, 6) ^ 8'h05;
            assign out_byte = aes_pkg::gf_inv(pre);
        end
        else
        begin : g_fwd
            aes_pkg::byte_t inv_b;

            assign inv_b = aes_pkg::gf_inv(in_byte);

            // affine map b ^ rotations by 1..4 ^ 0x63
            assign out_byte = inv_b
                            ^ rotl(inv_b, 1)
                            ^ rotl(inv_b, 2)
                            ^ rotl(inv_b, 3)
                            ^ rotl(inv_b, 4)
                            ^ 8'h63;
        end
    endgenerate

endmodule

`default_nettype wire

//--- sim/aes_decrypter_tb.sv
`timescale 1ns/10ps
`default_nettype none

module aes_decrypter_tb;

    localparam int NUM_VECTORS = 7;
    localparam int DONE_EDGES  = 21;                     // edges from start edge to done
    localparam int CYCLE_LIMIT = NUM_VECTORS * 30 + 50;
    localparam int MAX_GAP     = 5;

    typedef struct packed {
        aes_pkg::block_t key;
        aes_pkg::block_t cipher;
        aes_pkg::block_t plain;
        logic            stray_start;  // pulse start again while busy
    } vector_t;

    logic            clk;
    logic            rst;
    logic            start;
    aes_pkg::block_t cipher_text;
    aes_pkg::block_t key;
    logic            busy;
    logic            done;
    aes_pkg::block_t plain_text;

    vector_t         vectors [NUM_VECTORS];
    aes_pkg::block_t held_plain;  // last result that must stay on the output
    integer          seed;
    int              cycles;

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    aes_decrypter uut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cipher_text (cipher_text),
        .key         (key),
        .busy        (busy),
        .done        (done),
        .plain_text  (plain_text)
    );

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1);
    endtask

    // FIPS-197 appendix B and C.1, all-zero key, SP 800-38A ECB
    task automatic load_vectors();
        vectors[0] = '{key: 128'h000102030405060708090a0b0c0d0e0f,
                       cipher: 128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                       plain: 128'h00112233445566778899aabbccddeeff,
                       stray_start: 1'b0};
        vectors[1] = '{key: 128'h2b7e151628aed2a6abf7158809cf4f3c,
                       cipher: 128'h3925841d02dc09fbdc118597196a0b32,
                       plain: 128'h3243f6a8885a308d313198a2e0370734,
                       stray_start: 1'b1};
        vectors[2] = '{key: 128'h00000000000000000000000000000000,
                       cipher: 128'h66e94bd4ef8a2c3b884cfa59ca342b2e,
                       plain: 128'h00000000000000000000000000000000,
                       stray_start: 1'b0};
        vectors[3] = '{key: 128'h2b7e151628aed2a6abf7158809cf4f3c,
                       cipher: 128'h3ad77bb40d7a3660a89ecaf32466ef97,
                       plain: 128'h6bc1bee22e409f96e93d7e117393172a,
                       stray_start: 1'b0};
        vectors[4] = '{key: 128'h2b7e151628aed2a6abf7158809cf4f3c,
                       cipher: 128'hf5d3d58503b9699de785895a96fdbaaf,
                       plain: 128'hae2d8a571e03ac9c9eb76fac45af8e51,
                       stray_start: 1'b1};
        vectors[5] = '{key: 128'h2b7e151628aed2a6abf7158809cf4f3c,
                       cipher: 128'h43b1cd7f598ece23881b00e3ed030688,
                       plain: 128'h30c81c46a35ce411e5fbc1191a0a52ef,
                       stray_start: 1'b0};
        vectors[6] = '{key: 128'h2b7e151628aed2a6abf7158809cf4f3c,
                       cipher: 128'h7b0c785e27e8ad3f8223207104725dd4,
                       plain: 128'hf69f2445df4f9b17ad2b417be66c3710,
                       stray_start: 1'b0};
    endtask

    function automatic aes_pkg::block_t random_block();
        return aes_pkg::block_t'({$random(seed), $random(seed), $random(seed), $random(seed)});
    endfunction

    // idle cycles where the output must not move
    task automatic idle_cycles(input int count);
        repeat (count)
        begin
            @(posedge clk);
            start <= 1'b0;
            @(negedge clk);
            assert (busy === 1'b0 && done === 1'b0)
            else
                stop_on_error($sformatf("Mismatch at %0d ns: busy %b done %b while idle",
                                        $time, busy, done));
            assert (plain_text === held_plain)
            else
                stop_on_error($sformatf("Mismatch at %0d ns: plain_text %h, held %h",
                                        $time, plain_text, held_plain));
        end
    endtask

    task automatic run_vector(input int idx);
        vector_t v;
        int      n;
        v = vectors[idx];
        n = 0;
        @(posedge clk);
        key         <= v.key;
        cipher_text <= v.cipher;
        start       <= 1'b1;
        @(posedge clk);  // start edge
        start <= 1'b0;
        @(negedge clk);
        while (done !== 1'b1)
        begin
            assert (busy === 1'b1)
            else
                stop_on_error($sformatf("Mismatch at %0d ns: busy low %0d cycles into vector %0d",
                                        $time, n, idx));
            assert (plain_text === held_plain)
            else
                stop_on_error($sformatf("Mismatch at %0d ns: plain_text %h changed while busy",
                                        $time, plain_text));
            @(posedge clk);
            n++;
            if (v.stray_start && n == 4)
            begin
                start       <= 1'b1;
                key         <= random_block();
                cipher_text <= random_block();
            end
            else
                start <= 1'b0;
            @(negedge clk);
        end
        assert (n == DONE_EDGES)
        else
            stop_on_error($sformatf("Mismatch at %0d ns: done after %0d edges, expected %0d",
                                    $time, n, DONE_EDGES));
        assert (busy === 1'b0)
        else
            stop_on_error($sformatf("Mismatch at %0d ns: busy still high with done", $time));
        assert (plain_text === v.plain)
        else
            stop_on_error($sformatf("Mismatch at %0d ns: vector %0d plain_text %h, expected %h",
                                    $time, idx, plain_text, v.plain));
        held_plain = v.plain;
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        assert (cycles < CYCLE_LIMIT)
        else
            stop_on_error($sformatf("run did not finish within %0d clock cycles", CYCLE_LIMIT));
    end

    initial
    begin
        int gap;
        cycles      = 0;
        seed        = 33480;
        start       = 1'b0;
        cipher_text = '0;
        key         = '0;
        held_plain  = '0;
        load_vectors();

        do
            @(negedge clk);
        while (rst !== 1'b0);

        assert (busy === 1'b0 && done === 1'b0)
        else
            stop_on_error($sformatf("Mismatch at %0d ns: busy %b done %b after reset",
                                    $time, busy, done));
        assert (plain_text === '0)
        else
            stop_on_error($sformatf("Mismatch at %0d ns: plain_text %h after reset",
                                    $time, plain_text));

        for (int i = 0; i < NUM_VECTORS; i++)
        begin
            gap = int'($unsigned($random(seed)) % (MAX_GAP + 1));
            idle_cycles(gap);
            run_vector(i);
        end
        idle_cycles(2);  // result holds after the last done

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam time HALF_PERIOD  = 50ns;  // 100 ns clock
    localparam int  RESET_CYCLES = 3;

    initial
    begin
        clk = 1'b0;
        forever
            #(HALF_PERIOD) clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire
